/* rtl/pad_dmac_params.svh */
/* Mirror-padding DMA engine parameters
   Bus widths, burst length, word size and matrix limits */
`ifndef PAD_DMAC_PARAMS_SVH
`define PAD_DMAC_PARAMS_SVH

`define PAD_ADDR_W      32  // Byte address
`define PAD_DATA_W      32  // One pixel
`define PAD_DIM_W       6   // Matrix width or position
`define PAD_COORD_W     7   // Signed 1-based coordinate

// Row burst and window edge
`define PAD_BURST_LEN   3
`define PAD_WORD_BYTES  4

// Legal source widths, even only
`define PAD_MIN_WIDTH   4
`define PAD_MAX_WIDTH   62

`endif

/* rtl/pad_geom_pkg.sv */
/* Matrix geometry for the padding engine
   Dimension and coordinate types, mirror and window-centre maps */
`include "pad_dmac_params.svh"
`default_nettype none

package pad_geom_pkg;

    typedef logic [`PAD_DIM_W-1:0]          dim_t;
    typedef logic signed [`PAD_COORD_W-1:0] coord_t;

    // Output row or column (0-based, padded) to 1-based source index
    function automatic coord_t mirror_src(input dim_t pos, input dim_t width);
        coord_t w;
        coord_t p;
        w = $signed({1'b0, width});
        p = $signed({1'b0, pos});
        if (pos == '0) begin
            return coord_t'(2);  // Top or left border reflects index 2
        end
        if (p == w + coord_t'(1)) begin
            return w - coord_t'(1);  // Far border reflects WIDTH-1
        end
        return p;
    endfunction

    // Block origin to window centre, kept inside 2..WIDTH-1
    function automatic coord_t clamp_centre(input dim_t origin, input dim_t width);
        coord_t c;
        coord_t hi;
        c  = $signed({1'b0, origin}) + coord_t'(1);
        hi = $signed({1'b0, width}) - coord_t'(1);
        if (c < coord_t'(2)) begin
            return coord_t'(2);
        end
        if (c > hi) begin
            return hi;
        end
        return c;
    endfunction

endpackage

`default_nettype wire

/* rtl/pad_bus_pkg.sv */
/* Memory bus and engine control types
   Address and pixel words, engine state encoding */
`include "pad_dmac_params.svh"
`default_nettype none

package pad_bus_pkg;

    typedef logic [`PAD_ADDR_W-1:0] addr_t;
    typedef logic [`PAD_DATA_W-1:0] pixel_t;

    // Top-level engine sequence
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        FETCH = 3'd1,  // 3x3 window read in progress
        WRITE = 3'd2,  // Four block pixels going out
        NEXT  = 3'd3,  // Advance to next block origin
        DONE  = 3'd4
    } eng_state_t;

endpackage

`default_nettype wire

/* rtl/pad_sequencer.sv */
/* Padding engine sequencer
   Latches the job, walks 2x2 block origins over the padded output
   and hands each block to the fetch and write units in turn */
`timescale 1ns/1ps
`include "pad_dmac_params.svh"
`default_nettype none

module pad_sequencer
    import pad_geom_pkg::*;
    import pad_bus_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire addr_t  src_addr_i,
    input  wire addr_t  dst_addr_i,
    input  wire dim_t   mat_width_i,
    input  wire         start_i,
    input  wire         fetch_done_i,
    input  wire         write_done_i,
    output logic        done_o,
    output logic        fetch_go_o,
    output logic        write_go_o,
    output addr_t       src_base_o,
    output addr_t       dst_base_o,
    output dim_t        width_o,
    output dim_t        block_row_o,
    output dim_t        block_col_o,
    output coord_t      centre_row_o,
    output coord_t      centre_col_o
);

    eng_state_t state_q;
    logic       last_col;
    logic       last_row;

    // Last origin in each direction equals WIDTH
    assign last_col = (block_col_o == width_o);
    assign last_row = (block_row_o == width_o);

    assign centre_row_o = clamp_centre(block_row_o, width_o);
    assign centre_col_o = clamp_centre(block_col_o, width_o);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            done_o      <= 1'b1;
            fetch_go_o  <= 1'b0;
            write_go_o  <= 1'b0;
            block_row_o <= '0;
            block_col_o <= '0;
        end else begin
            fetch_go_o <= 1'b0;  // Single-cycle pulses
            write_go_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        done_o      <= 1'b0;
                        block_row_o <= '0;
                        block_col_o <= '0;
                        fetch_go_o  <= 1'b1;
                        state_q     <= FETCH;
                    end
                end
                FETCH: begin
                    if (fetch_done_i) begin
                        write_go_o <= 1'b1;
                        state_q    <= WRITE;
                    end
                end
                WRITE: begin
                    if (write_done_i) begin
                        if (last_col && last_row) begin
                            done_o  <= 1'b1;
                            state_q <= DONE;
                        end else begin
                            state_q <= NEXT;
                        end
                    end
                end
                NEXT: begin
                    // Columns first, then step down one block row
                    if (last_col) begin
                        block_col_o <= '0;
                        block_row_o <= block_row_o + dim_t'(2);
                    end else begin
                        block_col_o <= block_col_o + dim_t'(2);
                    end
                    fetch_go_o <= 1'b1;
                    state_q    <= FETCH;
                end
                DONE: begin
                    if (!start_i) begin
                        state_q <= IDLE;  // Wait for start to drop
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Job configuration, held for the whole run
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            src_base_o <= src_addr_i;
            dst_base_o <= dst_addr_i;
            width_o    <= mat_width_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/pad_window_fetch.sv */
/* 3x3 window fetch unit
   Reads three source rows around the window centre as 3-beat bursts
   and stores the beats in a row-major window buffer */
`timescale 1ns/1ps
`include "pad_dmac_params.svh"
`default_nettype none

module pad_window_fetch
    import pad_geom_pkg::*;
    import pad_bus_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          fetch_go_i,
    input  wire addr_t   src_base_i,
    input  wire dim_t    width_i,
    input  wire coord_t  centre_row_i,
    input  wire coord_t  centre_col_i,
    input  wire          ar_ready_i,
    input  wire pixel_t  r_data_i,
    input  wire          r_last_i,
    input  wire          r_valid_i,
    output addr_t        ar_addr_o,
    output logic         ar_valid_o,
    output logic         r_ready_o,
    output pixel_t       win_o [0:8],
    output logic         fetch_done_o
);

    localparam logic [1:0] LAST_ROW = 2'(`PAD_BURST_LEN - 1);

    logic [1:0] row_idx;   // Window row being read
    logic [1:0] beat_idx;  // Beat within current burst
    logic [3:0] win_idx;
    logic       ar_hs;
    logic       r_hs;
    logic       row_end;

    // Start address of source columns centre-1..centre+1 in one window row
    function automatic addr_t row_addr(input logic [1:0] row);
        dim_t src_row;
        dim_t src_col;
        src_row = dim_t'(centre_row_i - coord_t'(2)) + dim_t'(row);  // 0-based
        src_col = dim_t'(centre_col_i - coord_t'(2));
        return src_base_i
            + (addr_t'(src_row) * addr_t'(width_i) + addr_t'(src_col)) * `PAD_WORD_BYTES;
    endfunction

    assign ar_hs   = ar_valid_o & ar_ready_i;
    assign r_hs    = r_valid_i & r_ready_o;
    assign row_end = r_hs & r_last_i;
    assign win_idx = 4'(row_idx) * 4'(`PAD_BURST_LEN) + 4'(beat_idx);

    assign fetch_done_o = row_end & (row_idx == LAST_ROW);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ar_valid_o <= 1'b0;
            r_ready_o  <= 1'b0;
            row_idx    <= '0;
            beat_idx   <= '0;
        end else begin
            if (fetch_go_i) begin
                ar_valid_o <= 1'b1;
                row_idx    <= '0;
                beat_idx   <= '0;
            end
            if (ar_hs) begin
                ar_valid_o <= 1'b0;
                r_ready_o  <= 1'b1;  // Accept data only for an issued burst
            end
            if (r_hs) begin
                beat_idx <= beat_idx + 2'd1;
                if (r_last_i) begin
                    beat_idx  <= '0;
                    r_ready_o <= 1'b0;
                    if (row_idx != LAST_ROW) begin
                        row_idx    <= row_idx + 2'd1;
                        ar_valid_o <= 1'b1;  // Next row only after last beat
                    end
                end
            end
        end
    end

    // Burst address and window storage
    always_ff @(posedge clk) begin
        if (fetch_go_i) begin
            ar_addr_o <= row_addr(2'd0);
        end else if (row_end && row_idx != LAST_ROW) begin
            ar_addr_o <= row_addr(row_idx + 2'd1);
        end
        if (r_hs) begin
            win_o[win_idx] <= r_data_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/pad_block_select.sv */
/* Block pixel selector
   Picks the four padded output values of a 2x2 block from the
   3x3 source window by applying the mirror rule */
`timescale 1ns/1ps
`include "pad_dmac_params.svh"
`default_nettype none

module pad_block_select
    import pad_geom_pkg::*;
    import pad_bus_pkg::*;
(
    input  wire pixel_t  win_i [0:8],
    input  wire dim_t    block_row_i,
    input  wire dim_t    block_col_i,
    input  wire dim_t    width_i,
    input  wire coord_t  centre_row_i,
    input  wire coord_t  centre_col_i,
    output pixel_t       pix_o [0:3]
);

    // Window entry for one output coordinate of the block
    function automatic pixel_t pick(input dim_t out_r, input dim_t out_c);
        coord_t     rel_r;
        coord_t     rel_c;
        logic [3:0] idx;
        rel_r = mirror_src(out_r, width_i) - centre_row_i + coord_t'(1);  // 0..2
        rel_c = mirror_src(out_c, width_i) - centre_col_i + coord_t'(1);
        idx   = 4'(rel_r) * 4'(`PAD_BURST_LEN) + 4'(rel_c);
        return win_i[idx];
    endfunction

    assign pix_o[0] = pick(block_row_i, block_col_i);                         // TL
    assign pix_o[1] = pick(block_row_i, block_col_i + dim_t'(1));             // TR
    assign pix_o[2] = pick(block_row_i + dim_t'(1), block_col_i);             // BL
    assign pix_o[3] = pick(block_row_i + dim_t'(1), block_col_i + dim_t'(1)); // BR

endmodule

`default_nettype wire

/* rtl/pad_block_writer.sv */
/* Block writer
   Sends the four pixels of a 2x2 block as single-beat writes,
   each one AW, then W, then B before the next pixel */
`timescale 1ns/1ps
`include "pad_dmac_params.svh"
`default_nettype none

module pad_block_writer
    import pad_geom_pkg::*;
    import pad_bus_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          write_go_i,
    input  wire addr_t   dst_base_i,
    input  wire dim_t    width_i,
    input  wire dim_t    block_row_i,
    input  wire dim_t    block_col_i,
    input  wire pixel_t  pix_i [0:3],
    input  wire          aw_ready_i,
    input  wire          w_ready_i,
    input  wire          b_valid_i,
    output addr_t        aw_addr_o,
    output logic         aw_valid_o,
    output pixel_t       w_data_o,
    output logic         w_valid_o,
    output logic         b_ready_o,
    output logic         write_done_o
);

    pixel_t     pix_q [0:3];  // Block copy, order TL TR BL BR
    logic [1:0] pix_idx;
    logic       aw_hs;
    logic       w_hs;
    logic       b_hs;

    // Destination byte address; padded matrix rows are WIDTH+2 words
    function automatic addr_t pixel_addr(input logic [1:0] idx);
        addr_t row;
        addr_t col;
        row = addr_t'(block_row_i) + addr_t'(idx[1]);
        col = addr_t'(block_col_i) + addr_t'(idx[0]);
        return dst_base_i + (row * (addr_t'(width_i) + addr_t'(2)) + col) * `PAD_WORD_BYTES;
    endfunction

    assign aw_hs = aw_valid_o & aw_ready_i;
    assign w_hs  = w_valid_o & w_ready_i;
    assign b_hs  = b_valid_i & b_ready_o;

    assign w_data_o     = pix_q[pix_idx];
    assign write_done_o = b_hs & (pix_idx == 2'd3);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aw_valid_o <= 1'b0;
            w_valid_o  <= 1'b0;
            b_ready_o  <= 1'b0;
            pix_idx    <= '0;
        end else begin
            if (write_go_i) begin
                aw_valid_o <= 1'b1;
                pix_idx    <= '0;
            end
            if (aw_hs) begin
                aw_valid_o <= 1'b0;
                w_valid_o  <= 1'b1;
            end
            if (w_hs) begin
                w_valid_o <= 1'b0;
                b_ready_o <= 1'b1;
            end
            if (b_hs) begin
                b_ready_o <= 1'b0;
                if (pix_idx != 2'd3) begin
                    pix_idx    <= pix_idx + 2'd1;
                    aw_valid_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_go_i) begin
            for (int i = 0; i < 4; i++) begin
                pix_q[i] <= pix_i[i];
            end
            aw_addr_o <= pixel_addr(2'd0);
        end else if (b_hs && pix_idx != 2'd3) begin
            aw_addr_o <= pixel_addr(pix_idx + 2'd1);  // Next pixel of the block
        end
    end

endmodule

`default_nettype wire

/* rtl/pad_dmac_top.sv */
/* Mirror-padding copy engine
   Copies a WIDTH x WIDTH matrix into a (WIDTH+2) square with a
   reflected one-pixel border, one 2x2 block at a time */
`timescale 1ns/1ps
`include "pad_dmac_params.svh"
`default_nettype none

module pad_dmac_top
    import pad_geom_pkg::*;
    import pad_bus_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    // Job configuration
    input  wire addr_t   src_addr_i,
    input  wire addr_t   dst_addr_i,
    input  wire dim_t    mat_width_i,
    input  wire          start_i,
    output wire          done_o,
    // Read address and data
    output wire addr_t   ar_addr_o,
    output wire          ar_valid_o,
    input  wire          ar_ready_i,
    input  wire pixel_t  r_data_i,
    input  wire          r_last_i,
    input  wire          r_valid_i,
    output wire          r_ready_o,
    // Write address, data and response
    output wire addr_t   aw_addr_o,
    output wire          aw_valid_o,
    input  wire          aw_ready_i,
    output wire pixel_t  w_data_o,
    output wire          w_valid_o,
    input  wire          w_ready_i,
    input  wire          b_valid_i,
    output wire          b_ready_o
);

    wire         fetch_go;
    wire         fetch_done;
    wire         write_go;
    wire         write_done;
    wire addr_t  src_base;
    wire addr_t  dst_base;
    wire dim_t   width;
    wire dim_t   block_row;
    wire dim_t   block_col;
    wire coord_t centre_row;
    wire coord_t centre_col;
    pixel_t      win [0:8];
    pixel_t      blk_pix [0:3];

    pad_sequencer pad_sequencer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .src_addr_i   (src_addr_i),
        .dst_addr_i   (dst_addr_i),
        .mat_width_i  (mat_width_i),
        .start_i      (start_i),
        .fetch_done_i (fetch_done),
        .write_done_i (write_done),
        .done_o       (done_o),
        .fetch_go_o   (fetch_go),
        .write_go_o   (write_go),
        .src_base_o   (src_base),
        .dst_base_o   (dst_base),
        .width_o      (width),
        .block_row_o  (block_row),
        .block_col_o  (block_col),
        .centre_row_o (centre_row),
        .centre_col_o (centre_col)
    );

    pad_window_fetch pad_window_fetch_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_go_i   (fetch_go),
        .src_base_i   (src_base),
        .width_i      (width),
        .centre_row_i (centre_row),
        .centre_col_i (centre_col),
        .ar_ready_i   (ar_ready_i),
        .r_data_i     (r_data_i),
        .r_last_i     (r_last_i),
        .r_valid_i    (r_valid_i),
        .ar_addr_o    (ar_addr_o),
        .ar_valid_o   (ar_valid_o),
        .r_ready_o    (r_ready_o),
        .win_o        (win),
        .fetch_done_o (fetch_done)
    );

    pad_block_select pad_block_select_i (
        .win_i        (win),
        .block_row_i  (block_row),
        .block_col_i  (block_col),
        .width_i      (width),
        .centre_row_i (centre_row),
        .centre_col_i (centre_col),
        .pix_o        (blk_pix)
    );

    pad_block_writer pad_block_writer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_go_i   (write_go),
        .dst_base_i   (dst_base),
        .width_i      (width),
        .block_row_i  (block_row),
        .block_col_i  (block_col),
        .pix_i        (blk_pix),
        .aw_ready_i   (aw_ready_i),
        .w_ready_i    (w_ready_i),
        .b_valid_i    (b_valid_i),
        .aw_addr_o    (aw_addr_o),
        .aw_valid_o   (aw_valid_o),
        .w_data_o     (w_data_o),
        .w_valid_o    (w_valid_o),
        .b_ready_o    (b_ready_o),
        .write_done_o (write_done)
    );

endmodule

`default_nettype wire

/* test/pad_dmac_sva.sv */
/* Bound protocol assertions for the padding engine
   Request hold until ready, quiet buses in reset, done behaviour */
`timescale 1ns/1ps
`default_nettype none

module pad_dmac_sva
    import pad_bus_pkg::*;
(
    input wire          clk,
    input wire          rst_n,
    input wire          start_i,
    input wire          done_o,
    input wire addr_t   ar_addr_o,
    input wire          ar_valid_o,
    input wire          ar_ready_i,
    input wire addr_t   aw_addr_o,
    input wire          aw_valid_o,
    input wire          aw_ready_i,
    input wire pixel_t  w_data_o,
    input wire          w_valid_o,
    input wire          w_ready_i
);

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
        else $error("AR valid or address changed before ready");

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
        else $error("AW valid or address changed before ready");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o))
        else $error("W valid or data changed before ready");

    // Request channels stay quiet while reset is applied
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !ar_valid_o && !aw_valid_o && !w_valid_o)
        else $error("Request valid high during reset");

    done_hold: assert property (@(posedge clk) disable iff (!rst_n)
        done_o && !start_i |=> done_o)
        else $error("done_o fell without a start");

endmodule

bind pad_dmac_top pad_dmac_sva pad_dmac_sva_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_i),
    .done_o     (done_o),
    .ar_addr_o  (ar_addr_o),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .aw_addr_o  (aw_addr_o),
    .aw_valid_o (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .w_data_o   (w_data_o),
    .w_valid_o  (w_valid_o),
    .w_ready_i  (w_ready_i)
);

`default_nettype wire

/* test/pad_dmac_tb.sv */
/* Testbench for the mirror-padding copy engine
   Clock source, memory model with random stalls, case table
   and a full check of every padded destination word */
`timescale 1ns/1ps
`include "pad_dmac_params.svh"
`default_nettype none

module pad_dmac_clkgen (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;  // 4 ns period
    end
endmodule

module pad_dmac_tb
    import pad_geom_pkg::*;
    import pad_bus_pkg::*;
();

    localparam int NCASES    = 6;
    localparam int MEM_WORDS = 1024;

    // Case table columns are width, source, destination, stalls and write count
    int    case_w      [NCASES] = '{4, 6, 8, 4, 6, 8};
    addr_t case_src    [NCASES] = '{32'h000, 32'h200, 32'h400, 32'h000, 32'h200, 32'h400};
    addr_t case_dst    [NCASES] = '{32'h100, 32'h300, 32'h600, 32'h100, 32'h300, 32'h600};
    bit    case_stall  [NCASES] = '{0, 0, 0, 1, 1, 1};
    int    case_writes [NCASES] = '{36, 64, 100, 36, 64, 100};

    logic   clk;
    logic   rst_n       = 1'b0;
    addr_t  src_addr_i  = '0;
    addr_t  dst_addr_i  = '0;
    dim_t   mat_width_i = '0;
    logic   start_i     = 1'b0;
    logic   ar_ready_i  = 1'b0;
    pixel_t r_data_i    = '0;
    logic   r_last_i    = 1'b0;
    logic   r_valid_i   = 1'b0;
    logic   aw_ready_i  = 1'b0;
    logic   w_ready_i   = 1'b0;
    logic   b_valid_i   = 1'b0;
    wire          done_o;
    wire addr_t   ar_addr_o;
    wire          ar_valid_o;
    wire          r_ready_o;
    wire addr_t   aw_addr_o;
    wire          aw_valid_o;
    wire pixel_t  w_data_o;
    wire          w_valid_o;
    wire          b_ready_o;

    pixel_t      mem      [MEM_WORDS];
    int          wr_count [MEM_WORDS];
    addr_t       exp_ar_q [$];  // Burst addresses in issue order
    addr_t       exp_aw_q [$];
    logic [31:0] rng         = 32'h225a6c1f;
    bit          stall_en    = 1'b0;
    bit          rd_active   = 1'b0;
    bit          rd_xfer     = 1'b0;
    bit          b_xfer      = 1'b0;
    int          rd_beat     = 0;
    addr_t       rd_addr     = '0;
    int          wr_phase    = 0;  // 0 AW, 1 W, 2 B
    addr_t       wr_addr     = '0;
    int          wr_total    = 0;
    int          val_errs    = 0;
    int          other_errs  = 0;
    int          cycles      = 0;
    int          cycle_limit = 0;

    pad_dmac_clkgen pad_dmac_clkgen_i (.clk_o(clk));

    pad_dmac_top pad_dmac_top_i (.*);

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // About one stall in four when stalls are on
    function automatic logic draw_accept();
        logic [31:0] r;
        r = next_rand();
        return !stall_en || (r[1:0] != 2'b00);
    endfunction

    function automatic int word_index(input addr_t a);
        return int'(a[11:2]);
    endfunction

    // Padded index to 1-based source index
    function automatic int reflect(input int p, input int w);
        if (p == 0) begin
            return 2;
        end
        if (p == w + 1) begin
            return w - 1;  // Far border skips the edge pixel
        end
        return p;
    endfunction

    function automatic int window_centre(input int origin, input int w);
        int c;
        c = origin + 1;
        if (c < 2) begin
            c = 2;
        end
        if (c > w - 1) begin
            c = w - 1;
        end
        return c;
    endfunction

    function automatic pixel_t source_pixel(input int n, input int r, input int c);
        return pixel_t'(r * 256 + c + n * 32'h10000);  // Case number as seed offset
    endfunction

    function automatic int timeout_cycles();
        int total;
        total = 1000;  // Reset and start handshakes
        for (int n = 0; n < NCASES; n++) begin
            total += (case_w[n] / 2 + 1) * (case_w[n] / 2 + 1) * 13 * 8;
        end
        return total;
    endfunction

    task automatic note_failure(input string msg);
        other_errs++;
        $display("%s", msg);
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            val_errs++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            val_errs++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic fill_memory(input int n);
        int base;
        base = word_index(case_src[n]);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]      = 32'hee000000 ^ (i * 32'h9e3779b1);  // Background differs per word
            wr_count[i] = 0;
        end
        for (int r = 1; r <= case_w[n]; r++) begin
            for (int c = 1; c <= case_w[n]; c++) begin
                mem[base + (r - 1) * case_w[n] + c - 1] = source_pixel(n, r, c);
            end
        end
        wr_total = 0;
    endtask

    // Three row bursts and four pixel writes per block in row order
    task automatic build_expected(input int n);
        int w;
        int cr;
        int cc;
        int ofs;
        w = case_w[n];
        for (int br = 0; br <= w; br += 2) begin
            for (int bc = 0; bc <= w; bc += 2) begin
                cr = window_centre(br, w);
                cc = window_centre(bc, w);
                for (int k = 0; k < 3; k++) begin
                    ofs = ((cr - 2 + k) * w + cc - 2) * 4;
                    exp_ar_q.push_back(case_src[n] + addr_t'(ofs));
                end
                for (int k = 0; k < 4; k++) begin
                    ofs = ((br + k / 2) * (w + 2) + bc + k % 2) * 4;
                    exp_aw_q.push_back(case_dst[n] + addr_t'(ofs));
                end
            end
        end
    endtask

    // A transfer seen here completes on the next rising edge
    task automatic serve_read();
        if (rd_xfer) begin
            r_valid_i = 1'b0;
        end
        rd_xfer = 1'b0;
        if (rd_active) begin
            ar_ready_i = 1'b0;
            if (!r_valid_i) begin
                r_valid_i = draw_accept();
            end
            r_data_i = mem[word_index(rd_addr + addr_t'(rd_beat * 4))];
            r_last_i = (rd_beat == `PAD_BURST_LEN - 1);
            if (r_valid_i && r_ready_o) begin
                rd_xfer = 1'b1;
                rd_beat++;
                rd_active = !r_last_i;
            end
        end else begin
            ar_ready_i = draw_accept();
            if (ar_valid_o && ar_ready_i) begin
                if (exp_ar_q.size() == 0) begin
                    note_failure("Read burst issued when none was expected");
                end else begin
                    check_addr("ar_addr_o", ar_addr_o, exp_ar_q.pop_front());
                end
                rd_addr   = ar_addr_o;
                rd_beat   = 0;
                rd_active = 1'b1;
            end
        end
    endtask

    task automatic serve_write();
        if (b_xfer) begin
            b_valid_i = 1'b0;
        end
        b_xfer = 1'b0;
        case (wr_phase)
            0: begin
                aw_ready_i = draw_accept();
                if (aw_valid_o && aw_ready_i) begin
                    if (exp_aw_q.size() == 0) begin
                        note_failure("Write issued when none was expected");
                    end else begin
                        check_addr("aw_addr_o", aw_addr_o, exp_aw_q.pop_front());
                    end
                    wr_addr  = aw_addr_o;
                    wr_phase = 1;
                end
            end
            1: begin
                aw_ready_i = 1'b0;
                w_ready_i  = draw_accept();
                if (w_valid_o && w_ready_i) begin
                    mem[word_index(wr_addr)] = w_data_o;
                    wr_count[word_index(wr_addr)]++;
                    wr_total++;
                    wr_phase = 2;
                end
            end
            default: begin
                w_ready_i = 1'b0;
                if (!b_valid_i) begin
                    b_valid_i = draw_accept();
                end
                if (b_valid_i && b_ready_o) begin
                    b_xfer   = 1'b1;
                    wr_phase = 0;
                end
            end
        endcase
    endtask

    // Memory model
    always @(negedge clk) begin
        if (!rst_n) begin
            ar_ready_i = 1'b0;
            r_valid_i  = 1'b0;
            aw_ready_i = 1'b0;
            w_ready_i  = 1'b0;
            b_valid_i  = 1'b0;
            rd_active  = 1'b0;
            rd_xfer    = 1'b0;
            b_xfer     = 1'b0;
            wr_phase   = 0;
        end else begin
            serve_read();
            serve_write();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the engine did not finish", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic verify_case(input int n);
        int w;
        int idx;
        w = case_w[n];
        if (exp_ar_q.size() != 0 || exp_aw_q.size() != 0) begin
            note_failure($sformatf("Case %0d ended with %0d bursts and %0d writes missing",
                                   n, exp_ar_q.size(), exp_aw_q.size()));
            exp_ar_q.delete();
            exp_aw_q.delete();
        end
        if (wr_total != case_writes[n]) begin
            note_failure($sformatf("Case %0d made %0d writes instead of %0d",
                                   n, wr_total, case_writes[n]));
        end
        for (int r = 0; r < w + 2; r++) begin
            for (int c = 0; c < w + 2; c++) begin
                idx = word_index(case_dst[n]) + r * (w + 2) + c;
                check_pixel($sformatf("dst[%0d][%0d]", r, c), mem[idx],
                            source_pixel(n, reflect(r, w), reflect(c, w)));
                if (wr_count[idx] != 1) begin
                    note_failure($sformatf("Case %0d word at row %0d col %0d written %0d times",
                                           n, r, c, wr_count[idx]));
                end
            end
        end
    endtask

    task automatic run_case(input int n);
        fill_memory(n);
        build_expected(n);
        stall_en    <= case_stall[n];
        src_addr_i  <= case_src[n];
        dst_addr_i  <= case_dst[n];
        mat_width_i <= dim_t'(case_w[n]);
        start_i     <= 1'b1;
        @(negedge clk);
        if (done_o !== 1'b0) begin
            note_failure($sformatf("Case %0d: done_o did not fall after start", n));
        end
        while (done_o !== 1'b1) begin
            @(negedge clk);
        end
        repeat (2) begin
            @(negedge clk);
            if (done_o !== 1'b1) begin
                note_failure("done_o dropped while start_i was still high");
            end
        end
        start_i <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            if (done_o !== 1'b1) begin
                note_failure("done_o dropped after start_i fell");
            end
        end
        verify_case(n);
    endtask

    initial begin
        cycle_limit = timeout_cycles();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (done_o !== 1'b1) begin
            note_failure("done_o is not high after reset");
        end
        if ({ar_valid_o, aw_valid_o, w_valid_o, r_ready_o, b_ready_o} !== 5'b0) begin
            note_failure("A valid or ready output is high after reset");
        end
        for (int n = 0; n < NCASES; n++) begin
            run_case(n);
        end
        $display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pad_dmac.f */
+incdir+rtl
rtl/pad_geom_pkg.sv
rtl/pad_bus_pkg.sv
rtl/pad_sequencer.sv
rtl/pad_window_fetch.sv
rtl/pad_block_select.sv
rtl/pad_block_writer.sv
rtl/pad_dmac_top.sv
test/pad_dmac_sva.sv
test/pad_dmac_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := pad_dmac_tb
FLIST     := pad_dmac.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := === FAIL ===
SRCS      := $(shell grep '\.sv$$' $(FLIST)) rtl/pad_dmac_params.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
